/* source/sv32_defines.svh */
`ifndef SV32_DEFINES_SVH
`define SV32_DEFINES_SVH

// TLB geometry
`define SV32_TLB_ENTRIES 8
`define SV32_TLB_IDX_W   3

// Access type codes
`define SV32_ACC_LOAD  2'd0
`define SV32_ACC_STORE 2'd1
`define SV32_ACC_FETCH 2'd2

// Page level codes
`define SV32_LVL_4M 2'd1  // Superpage leaf at level 1
`define SV32_LVL_4K 2'd2  // Leaf at level 0

// PTE flag positions
`define SV32_PTE_V 0
`define SV32_PTE_R 1
`define SV32_PTE_W 2
`define SV32_PTE_X 3

`endif

/* source/sv32_pkg.sv */
package sv32_pkg;

    // Virtual address as issued by the core
    typedef logic [31:0] vaddr_t;

    // Physical address, truncated to 32 bits
    typedef logic [31:0] paddr_t;

    // Raw page table entry
    typedef logic [31:0] pte_t;

    // VPN[1] in the upper ten bits, VPN[0] below
    typedef logic [19:0] vpn_t;

    // Root page table number from satp
    typedef logic [19:0] ppn_t;

    // Page level, 4M or 4K code
    typedef logic [1:0] level_t;

    // Load, store or fetch
    typedef logic [1:0] access_t;

    // Walker FSM
    typedef enum logic [2:0] {
        IDLE,    // Waiting for a request
        LOOKUP,  // TLB query on the captured address
        L1_REQ,  // Level-1 PTE read
        L0_REQ,  // Level-0 PTE read
        RESP     // Response from the walked PTE
    } ptw_state_t;

endpackage

/* source/sv32_tlb.sv */
`timescale 1ns/1ps
`include "sv32_defines.svh"

module sv32_tlb (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                flush_i,

    // Lookup port
    input  sv32_pkg::vaddr_t    query_vaddr_i,
    output logic                query_hit_o,
    output sv32_pkg::pte_t      query_pte_o,
    output sv32_pkg::level_t    query_level_o,

    // Refill port
    input  logic                update_valid_i,
    input  sv32_pkg::vpn_t      update_vpn_i,
    input  sv32_pkg::pte_t      update_pte_i,
    input  sv32_pkg::level_t    update_level_i
);

    // Entry state
    logic [`SV32_TLB_ENTRIES-1:0] valid_q;
    sv32_pkg::vpn_t               vpn_q   [`SV32_TLB_ENTRIES];
    sv32_pkg::pte_t               pte_q   [`SV32_TLB_ENTRIES];
    sv32_pkg::level_t             level_q [`SV32_TLB_ENTRIES];

    logic [`SV32_TLB_IDX_W-1:0]   ptr_q;  // Next slot to replace

    // Address split
    logic [9:0]                   q_vpn1;
    logic [9:0]                   q_vpn0;

    logic                         hit;
    sv32_pkg::pte_t               hit_pte;
    sv32_pkg::level_t             hit_level;

    assign q_vpn1 = query_vaddr_i[31:22];
    assign q_vpn0 = query_vaddr_i[21:12];

    // Fully associative match over all entries
    always_comb begin
        hit       = 1'b0;
        hit_pte   = '0;
        hit_level = '0;
        for (int i = 0; i < `SV32_TLB_ENTRIES; i++) begin
            if (valid_q[i] && (vpn_q[i][19:10] == q_vpn1)) begin
                if (level_q[i] == `SV32_LVL_4M) begin
                    // Superpage ignores VPN[0]
                    hit       = 1'b1;
                    hit_pte   = pte_q[i];
                    hit_level = level_q[i];
                end else if ((level_q[i] == `SV32_LVL_4K) &&
                             (vpn_q[i][9:0] == q_vpn0)) begin
                    hit       = 1'b1;
                    hit_pte   = pte_q[i];
                    hit_level = level_q[i];
                end
            end
        end
    end

    assign query_hit_o   = hit;
    assign query_pte_o   = hit_pte;
    assign query_level_o = hit_level;

    // Valid bits and replacement pointer
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
            ptr_q   <= '0;
        end else if (flush_i) begin
            valid_q <= '0;  // Whole-TLB flush wins over refill
            ptr_q   <= '0;
        end else if (update_valid_i) begin
            valid_q[ptr_q] <= 1'b1;
            ptr_q          <= ptr_q + 1'b1;  // Wraps after the last slot
        end
    end

    // Entry payload
    always_ff @(posedge clk) begin
        if (update_valid_i && !flush_i) begin
            vpn_q[ptr_q]   <= update_vpn_i;
            pte_q[ptr_q]   <= update_pte_i;
            level_q[ptr_q] <= update_level_i;
        end
    end

    // Only leaves of a known size get cached
    a_refill_level: assert property (
        @(posedge clk) disable iff (!rst_n)
        update_valid_i |-> (update_level_i == `SV32_LVL_4M) ||
                           (update_level_i == `SV32_LVL_4K)
    );

    // Walker refill and external flush are never concurrent
    a_refill_no_flush: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(update_valid_i && flush_i)
    );

endmodule

/* source/sv32_ptw.sv */
`timescale 1ns/1ps
`include "sv32_defines.svh"

module sv32_ptw (
    input  logic                 clk,
    input  logic                 rst_n,

    // Request and response
    input  logic                 req_valid_i,
    input  sv32_pkg::vaddr_t     req_vaddr_i,
    input  sv32_pkg::access_t    req_access_i,
    input  sv32_pkg::ppn_t       satp_ppn_i,
    output logic                 resp_valid_o,
    output sv32_pkg::paddr_t     resp_paddr_o,
    output logic                 resp_fault_o,
    output logic                 busy_o,

    // TLB
    output sv32_pkg::vaddr_t     tlb_vaddr_o,
    input  logic                 tlb_hit_i,
    input  sv32_pkg::pte_t       tlb_pte_i,
    input  sv32_pkg::level_t     tlb_level_i,
    output logic                 tlb_update_valid_o,
    output sv32_pkg::vpn_t       tlb_update_vpn_o,
    output sv32_pkg::pte_t       tlb_update_pte_o,
    output sv32_pkg::level_t     tlb_update_level_o,

    // PTE memory read port
    output logic                 mem_req_o,
    output sv32_pkg::paddr_t     mem_addr_o,
    input  logic                 mem_rvalid_i,
    input  sv32_pkg::pte_t       mem_rdata_i,

    // Permission check
    output sv32_pkg::pte_t       chk_pte_o,
    output sv32_pkg::level_t     chk_level_o,
    output sv32_pkg::access_t    chk_access_o,
    output sv32_pkg::vaddr_t     chk_vaddr_o,
    input  logic                 chk_fault_i,
    input  sv32_pkg::paddr_t     chk_paddr_i
);

    sv32_pkg::ptw_state_t state_q;
    sv32_pkg::vaddr_t     vaddr_q;
    sv32_pkg::access_t    access_q;
    sv32_pkg::pte_t       walk_pte_q;    // Leaf found by the walk
    sv32_pkg::level_t     walk_level_q;
    logic                 walk_fault_q;  // V clear or pointer at level 0
    logic                 rd_valid;
    logic                 rd_leaf;

    // Classify the returned PTE
    assign rd_valid = mem_rdata_i[`SV32_PTE_V];
    assign rd_leaf  = mem_rdata_i[`SV32_PTE_R] | mem_rdata_i[`SV32_PTE_X];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q            <= sv32_pkg::IDLE;
            vaddr_q            <= '0;
            access_q           <= '0;
            walk_pte_q         <= '0;
            walk_level_q       <= '0;
            walk_fault_q       <= 1'b0;
            mem_req_o          <= 1'b0;
            mem_addr_o         <= '0;
            tlb_update_valid_o <= 1'b0;
            resp_valid_o       <= 1'b0;
            resp_paddr_o       <= '0;
            resp_fault_o       <= 1'b0;
        end else begin
            resp_valid_o       <= 1'b0;  // Strobes last one cycle
            tlb_update_valid_o <= 1'b0;
            case (state_q)
                sv32_pkg::IDLE: begin
                    if (req_valid_i && !busy_o) begin
                        vaddr_q  <= req_vaddr_i;
                        access_q <= req_access_i;
                        state_q  <= sv32_pkg::LOOKUP;
                    end
                end
                sv32_pkg::LOOKUP: begin
                    walk_fault_q <= 1'b0;
                    if (tlb_hit_i) begin
                        // Response straight from the cached leaf
                        resp_valid_o <= 1'b1;
                        resp_fault_o <= chk_fault_i;
                        resp_paddr_o <= chk_fault_i ? '0 : chk_paddr_i;
                        state_q      <= sv32_pkg::IDLE;
                    end else begin
                        mem_req_o  <= 1'b1;
                        mem_addr_o <= {satp_ppn_i, 12'b0} + {20'b0, vaddr_q[31:22], 2'b00};
                        state_q    <= sv32_pkg::L1_REQ;
                    end
                end
                sv32_pkg::L1_REQ: begin
                    if (mem_rvalid_i) begin
                        mem_req_o <= 1'b0;
                        if (!rd_valid) begin
                            walk_fault_q <= 1'b1;
                            state_q      <= sv32_pkg::RESP;
                        end else if (rd_leaf) begin
                            walk_pte_q         <= mem_rdata_i;
                            walk_level_q       <= `SV32_LVL_4M;
                            tlb_update_valid_o <= 1'b1;
                            state_q            <= sv32_pkg::RESP;
                        end else begin
                            // Pointer, request drops for a cycle before level 0
                            mem_addr_o <= {mem_rdata_i[29:10], 12'b0} +
                                          {20'b0, vaddr_q[21:12], 2'b00};
                            state_q    <= sv32_pkg::L0_REQ;
                        end
                    end
                end
                sv32_pkg::L0_REQ: begin
                    if (mem_rvalid_i) begin
                        mem_req_o <= 1'b0;
                        if (rd_valid && rd_leaf) begin
                            walk_pte_q         <= mem_rdata_i;
                            walk_level_q       <= `SV32_LVL_4K;
                            tlb_update_valid_o <= 1'b1;
                        end else begin
                            walk_fault_q <= 1'b1;  // Invalid or another pointer
                        end
                        state_q <= sv32_pkg::RESP;
                    end else begin
                        mem_req_o <= 1'b1;
                    end
                end
                sv32_pkg::RESP: begin
                    resp_valid_o <= 1'b1;
                    resp_fault_o <= walk_fault_q | chk_fault_i;
                    resp_paddr_o <= (walk_fault_q | chk_fault_i) ? '0 : chk_paddr_i;
                    state_q      <= sv32_pkg::IDLE;
                end
                default: state_q <= sv32_pkg::IDLE;
            endcase
        end
    end

    // Held through the response cycle
    assign busy_o = (state_q != sv32_pkg::IDLE) || resp_valid_o;

    assign tlb_vaddr_o        = vaddr_q;
    assign tlb_update_vpn_o   = vaddr_q[31:12];
    assign tlb_update_pte_o   = walk_pte_q;
    assign tlb_update_level_o = walk_level_q;

    // Cached leaf during lookup, walked leaf otherwise
    assign chk_pte_o    = (state_q == sv32_pkg::LOOKUP) ? tlb_pte_i : walk_pte_q;
    assign chk_level_o  = (state_q == sv32_pkg::LOOKUP) ? tlb_level_i : walk_level_q;
    assign chk_access_o = access_q;
    assign chk_vaddr_o  = vaddr_q;

    a_addr_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (mem_req_o && !mem_rvalid_i) |=> $stable(mem_addr_o)
    );

    // Memory answers only an open request
    a_rvalid_pending: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_rvalid_i |-> mem_req_o
    );

endmodule

/* source/sv32_perm_check.sv */
`timescale 1ns/1ps
`include "sv32_defines.svh"

module sv32_perm_check (
    input  sv32_pkg::pte_t     pte_i,
    input  sv32_pkg::level_t   level_i,
    input  sv32_pkg::access_t  access_i,
    input  sv32_pkg::vaddr_t   vaddr_i,
    output logic               fault_o,
    output sv32_pkg::paddr_t   paddr_o
);

    logic pte_r;
    logic pte_w;
    logic pte_x;
    logic has_right;    // Access type allowed by the flags
    logic bad_wr;       // Reserved W without R
    logic misaligned;   // Superpage with low PPN bits set
    logic is_4m;

    assign pte_r = pte_i[`SV32_PTE_R];
    assign pte_w = pte_i[`SV32_PTE_W];
    assign pte_x = pte_i[`SV32_PTE_X];
    assign is_4m = (level_i == `SV32_LVL_4M);

    always_comb begin
        case (access_i)
            `SV32_ACC_LOAD:  has_right = pte_r;
            `SV32_ACC_STORE: has_right = pte_w;
            `SV32_ACC_FETCH: has_right = pte_x;
            default:         has_right = 1'b0;  // Unknown access never passes
        endcase
    end

    assign bad_wr     = pte_w & ~pte_r;
    assign misaligned = is_4m && (pte_i[19:10] != 10'b0);

    assign fault_o = bad_wr | ~has_right | misaligned;

    // PPN[1] always, PPN[0] only for 4 KB pages
    assign paddr_o = is_4m ? {pte_i[29:20], vaddr_i[21:0]}
                           : {pte_i[29:20], pte_i[19:10], vaddr_i[11:0]};

endmodule

/* source/sv32_mmu_top.sv */
`timescale 1ns/1ps

module sv32_mmu_top (
    input  logic                clk,
    input  logic                rst_n,

    // Translation request
    input  logic                req_valid_i,
    input  sv32_pkg::vaddr_t    req_vaddr_i,
    input  sv32_pkg::access_t   req_access_i,

    // Global controls
    input  sv32_pkg::ppn_t      satp_ppn_i,
    input  logic                flush_i,

    // Translation response
    output logic                resp_valid_o,
    output sv32_pkg::paddr_t    resp_paddr_o,
    output logic                resp_fault_o,
    output logic                busy_o,

    // PTE memory
    output logic                mem_req_o,
    output sv32_pkg::paddr_t    mem_addr_o,
    input  logic                mem_rvalid_i,
    input  sv32_pkg::pte_t      mem_rdata_i
);

    // Walker to TLB
    sv32_pkg::vaddr_t   tlb_vaddr;
    logic               tlb_hit;
    sv32_pkg::pte_t     tlb_pte;
    sv32_pkg::level_t   tlb_level;
    logic               tlb_update_valid;
    sv32_pkg::vpn_t     tlb_update_vpn;
    sv32_pkg::pte_t     tlb_update_pte;
    sv32_pkg::level_t   tlb_update_level;

    // Walker to permission check
    sv32_pkg::pte_t     chk_pte;
    sv32_pkg::level_t   chk_level;
    sv32_pkg::access_t  chk_access;
    sv32_pkg::vaddr_t   chk_vaddr;
    logic               chk_fault;
    sv32_pkg::paddr_t   chk_paddr;

    sv32_tlb u_tlb (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush_i        (flush_i),
        .query_vaddr_i  (tlb_vaddr),
        .query_hit_o    (tlb_hit),
        .query_pte_o    (tlb_pte),
        .query_level_o  (tlb_level),
        .update_valid_i (tlb_update_valid),
        .update_vpn_i   (tlb_update_vpn),
        .update_pte_i   (tlb_update_pte),
        .update_level_i (tlb_update_level)
    );

    sv32_ptw u_ptw (
        .clk                (clk),
        .rst_n              (rst_n),
        .req_valid_i        (req_valid_i),
        .req_vaddr_i        (req_vaddr_i),
        .req_access_i       (req_access_i),
        .satp_ppn_i         (satp_ppn_i),
        .resp_valid_o       (resp_valid_o),
        .resp_paddr_o       (resp_paddr_o),
        .resp_fault_o       (resp_fault_o),
        .busy_o             (busy_o),
        .tlb_vaddr_o        (tlb_vaddr),
        .tlb_hit_i          (tlb_hit),
        .tlb_pte_i          (tlb_pte),
        .tlb_level_i        (tlb_level),
        .tlb_update_valid_o (tlb_update_valid),
        .tlb_update_vpn_o   (tlb_update_vpn),
        .tlb_update_pte_o   (tlb_update_pte),
        .tlb_update_level_o (tlb_update_level),
        .mem_req_o          (mem_req_o),
        .mem_addr_o         (mem_addr_o),
        .mem_rvalid_i       (mem_rvalid_i),
        .mem_rdata_i        (mem_rdata_i),
        .chk_pte_o          (chk_pte),
        .chk_level_o        (chk_level),
        .chk_access_o       (chk_access),
        .chk_vaddr_o        (chk_vaddr),
        .chk_fault_i        (chk_fault),
        .chk_paddr_i        (chk_paddr)
    );

    sv32_perm_check u_perm (
        .pte_i    (chk_pte),
        .level_i  (chk_level),
        .access_i (chk_access),
        .vaddr_i  (chk_vaddr),
        .fault_o  (chk_fault),
        .paddr_o  (chk_paddr)
    );

endmodule

/* testbench/sv32_mmu_tb.sv */
`timescale 1ns/1ps
`include "sv32_defines.svh"

module sv32_mmu_tb;

    localparam int CLK_PERIOD      = 20;
    localparam int NUM_REQUESTS    = 38;  // Requests issued by the stimulus below
    localparam int WATCHDOG_CYCLES = NUM_REQUESTS * 40;
    localparam sv32_pkg::ppn_t ROOT_PPN = 20'h00001;  // Root table at 0x1000

    // PTE flag sets, X W R V
    localparam logic [3:0] PTR = 4'b0001;
    localparam logic [3:0] RO  = 4'b0011;
    localparam logic [3:0] WX  = 4'b1101;
    localparam logic [3:0] RW  = 4'b0111;
    localparam logic [3:0] XO  = 4'b1001;
    localparam logic [3:0] RX  = 4'b1011;
    localparam logic [3:0] RWX = 4'b1111;

    // Read-only, fetch-only, RWX, write+fetch without read 4 KB pages and one RX superpage
    localparam sv32_pkg::vaddr_t PERM_PAGES [5] = '{32'h0041_0010, 32'h0041_1020,
        32'h0041_2030, 32'h0041_3040, 32'h0100_0050};
    localparam int PERM_READS [5] = '{2, 2, 2, 2, 1};

    logic               clk = 1'b0;
    logic               rst_n;
    logic               req_valid;
    sv32_pkg::vaddr_t   req_vaddr;
    sv32_pkg::access_t  req_access;
    sv32_pkg::ppn_t     satp_ppn;
    logic               flush;
    logic               resp_valid;
    sv32_pkg::paddr_t   resp_paddr;
    logic               resp_fault;
    logic               busy;
    logic               mem_req;
    sv32_pkg::paddr_t   mem_addr;
    logic               mem_rvalid;
    sv32_pkg::pte_t     mem_rdata;

    sv32_pkg::pte_t     mem [0:4095];  // 16 KB of page tables
    logic [31:0]        rng_state = 32'd80198;
    logic               mem_req_seen = 1'b0;
    int                 mem_reads_total = 0;
    logic               exp_fault_q [$];
    sv32_pkg::paddr_t   exp_paddr_q [$];

    sv32_mmu_top u_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .req_valid_i  (req_valid),
        .req_vaddr_i  (req_vaddr),
        .req_access_i (req_access),
        .satp_ppn_i   (satp_ppn),
        .flush_i      (flush),
        .resp_valid_o (resp_valid),
        .resp_paddr_o (resp_paddr),
        .resp_fault_o (resp_fault),
        .busy_o       (busy),
        .mem_req_o    (mem_req),
        .mem_addr_o   (mem_addr),
        .mem_rvalid_i (mem_rvalid),
        .mem_rdata_i  (mem_rdata)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic sv32_pkg::pte_t make_pte(input logic [19:0] ppn, input logic [3:0] flags);
        return {2'b00, ppn, 6'b000000, flags};
    endfunction

    function automatic sv32_pkg::pte_t read_word(input sv32_pkg::paddr_t addr);
        return mem[addr[13:2]];
    endfunction

    // Expected translation, walked from the model memory
    function automatic void ref_walk(input sv32_pkg::vaddr_t va, input sv32_pkg::access_t acc,
                                     output logic fault, output sv32_pkg::paddr_t pa);
        sv32_pkg::pte_t pte;
        logic           leaf_4m;
        logic           right;
        pte     = read_word({satp_ppn, 12'h000} + {20'h0, va[31:22], 2'b00});
        leaf_4m = 1'b1;
        fault   = !pte[`SV32_PTE_V];
        if (!fault && !pte[`SV32_PTE_R] && !pte[`SV32_PTE_X]) begin
            leaf_4m = 1'b0;  // Pointer, one level down
            pte     = read_word({pte[29:10], 12'h000} + {20'h0, va[21:12], 2'b00});
            fault   = !pte[`SV32_PTE_V] || (!pte[`SV32_PTE_R] && !pte[`SV32_PTE_X]);
        end
        case (acc)
            `SV32_ACC_LOAD:  right = pte[`SV32_PTE_R];
            `SV32_ACC_STORE: right = pte[`SV32_PTE_W];
            default:         right = pte[`SV32_PTE_X];
        endcase
        if ((pte[`SV32_PTE_W] && !pte[`SV32_PTE_R]) || !right)
            fault = 1'b1;
        if (leaf_4m && (pte[19:10] != 10'h0))
            fault = 1'b1;  // Misaligned superpage
        pa = leaf_4m ? {pte[29:20], va[21:0]} : {pte[29:20], pte[19:10], va[11:0]};
    endfunction

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Test failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic set_word(input sv32_pkg::paddr_t addr, input sv32_pkg::pte_t value);
        mem[addr[13:2]] = value;
    endtask

    task automatic build_tables();
        for (int i = 0; i < 4096; i++) begin
            mem[i] = 32'(i) << 2;  // Byte address as filler, V clear
        end
        set_word(32'h1004, make_pte(20'h00002, PTR));
        set_word(32'h1008, make_pte(20'h2AC00, RW));
        set_word(32'h100C, make_pte(20'h3A805, RO));  // PPN[0] nonzero
        set_word(32'h1010, make_pte(20'h11400, RX));
        set_word(32'h1014, 32'h0);
        set_word(32'h1018, make_pte(20'h00003, PTR));
        for (int v = 0; v < 10; v++) begin
            set_word(32'h2000 + 32'(4 * v), make_pte(20'h50010 + 20'(v), RW));
        end
        set_word(32'h2040, make_pte(20'h61000, RO));
        set_word(32'h2044, make_pte(20'h62000, XO));
        set_word(32'h2048, make_pte(20'h63000, RWX));
        set_word(32'h204C, make_pte(20'h64000, WX));
        set_word(32'h2050, 32'h0);
        set_word(32'h2054, make_pte(20'h00003, PTR));  // Pointer where a leaf belongs
        set_word(32'h3000, make_pte(20'h70000, RW));
    endtask

    task automatic wait_idle();
        do begin
            @(posedge clk);
            #1;
        end while (busy);
    endtask

    task automatic issue_request(input sv32_pkg::vaddr_t va, input sv32_pkg::access_t acc,
                                 input logic exp_fault, input sv32_pkg::paddr_t exp_paddr,
                                 input int exp_reads);
        int reads_before;
        int cycles;
        wait_idle();
        exp_fault_q.push_back(exp_fault);
        exp_paddr_q.push_back(exp_paddr);
        reads_before = mem_reads_total;
        req_valid    = 1'b1;
        req_vaddr    = va;
        req_access   = acc;
        cycles       = 0;
        do begin
            @(posedge clk);
            #1;
            req_valid = 1'b0;
            cycles++;
            assert (busy) else
                stop_with_failure($sformatf("[ERROR] time %0t: busy low while %h is pending",
                    $time, va));
        end while (!resp_valid);
        assert (mem_reads_total - reads_before == exp_reads) else
            stop_with_failure($sformatf("[ERROR] time %0t: vaddr %h made %0d PTE reads, expected %0d",
                $time, va, mem_reads_total - reads_before, exp_reads));
        // TLB hit answers two cycles after the request
        assert (exp_reads != 0 || cycles == 2) else
            stop_with_failure($sformatf("[ERROR] time %0t: hit on vaddr %h took %0d cycles, expected 2",
                $time, va, cycles));
        @(posedge clk);
        #1;
        assert (!busy) else
            stop_with_failure($sformatf("[ERROR] time %0t: busy still high after the response",
                $time));
    endtask

    task automatic check_translation(input sv32_pkg::vaddr_t va, input sv32_pkg::access_t acc,
                                     input int exp_reads);
        logic             f;
        sv32_pkg::paddr_t p;
        ref_walk(va, acc, f, p);
        issue_request(va, acc, f, p, exp_reads);
    endtask

    task automatic flush_tlb();
        wait_idle();
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    // PTE memory, answers each request after 1 to 4 cycles
    initial begin
        int delay;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_rvalid = 1'b0;
            if (rst_n && mem_req) begin
                rng_state = xorshift32(rng_state);
                delay     = 1 + int'(rng_state % 32'd4);
                repeat (delay - 1) begin
                    @(posedge clk);
                    #1;
                end
                mem_rdata  = read_word(mem_addr);
                mem_rvalid = 1'b1;
            end
        end
    end

    // Rising edges of mem_req, one per PTE read
    always @(negedge clk) begin
        if (mem_req && !mem_req_seen)
            mem_reads_total++;
        mem_req_seen = mem_req;
    end

    always @(negedge clk) begin
        logic             exp_f;
        sv32_pkg::paddr_t exp_p;
        if (rst_n && resp_valid) begin
            assert (exp_fault_q.size() != 0) else
                stop_with_failure("A response arrived with no request outstanding");
            exp_f = exp_fault_q.pop_front();
            exp_p = exp_paddr_q.pop_front();
            assert (resp_fault == exp_f) else
                stop_with_failure($sformatf("[ERROR] time %0t: fault %0b, expected %0b",
                    $time, resp_fault, exp_f));
            assert (exp_f || resp_paddr == exp_p) else
                stop_with_failure($sformatf("[ERROR] time %0t: paddr %h, expected %h",
                    $time, resp_paddr, exp_p));
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        stop_with_failure("Watchdog expired before all requests were answered");
    end

    initial begin
        logic             old_f;
        logic             new_f;
        sv32_pkg::paddr_t old_p;
        sv32_pkg::paddr_t new_p;
        rst_n      = 1'b0;
        req_valid  = 1'b0;
        req_vaddr  = '0;
        req_access = '0;
        satp_ppn   = ROOT_PPN;
        flush      = 1'b0;
        build_tables();
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check_translation(32'h0040_0ABC, `SV32_ACC_LOAD, 2);   // 4 KB walk
        check_translation(32'h0092_3456, `SV32_ACC_STORE, 1);  // 4 MB leaf
        assert (resp_paddr[21:0] == 22'h12_3456) else
            stop_with_failure($sformatf("[ERROR] time %0t: superpage offset %h not passed through",
                $time, resp_paddr[21:0]));
        check_translation(32'h0040_0ABC, `SV32_ACC_LOAD, 0);
        check_translation(32'h00A0_0004, `SV32_ACC_FETCH, 0);  // Hit that faults, no X

        flush_tlb();
        check_translation(32'h0140_0000, `SV32_ACC_LOAD, 1);   // Zero root PTE
        check_translation(32'h0000_1000, `SV32_ACC_LOAD, 1);   // Filler root PTE
        check_translation(32'h0041_4000, `SV32_ACC_LOAD, 2);   // Invalid leaf
        check_translation(32'h0041_5000, `SV32_ACC_FETCH, 2);  // Pointer at level 0
        check_translation(32'h00C0_0000, `SV32_ACC_LOAD, 1);   // Misaligned superpage
        for (int p = 0; p < 5; p++) begin
            for (int acc = 0; acc < 3; acc++) begin
                check_translation(PERM_PAGES[p], 2'(acc), (acc == 0) ? PERM_READS[p] : 0);
            end
        end

        // Stale entry survives a PTE change until the flush
        flush_tlb();
        check_translation(32'h0180_0123, `SV32_ACC_LOAD, 2);
        ref_walk(32'h0180_0123, `SV32_ACC_LOAD, old_f, old_p);
        set_word(32'h3000, make_pte(20'h7ABCD, RW));
        ref_walk(32'h0180_0123, `SV32_ACC_LOAD, new_f, new_p);
        issue_request(32'h0180_0123, `SV32_ACC_LOAD, old_f, old_p, 0);
        flush_tlb();
        issue_request(32'h0180_0123, `SV32_ACC_LOAD, new_f, new_p, 2);

        // Nine pages through eight entries
        flush_tlb();
        for (int v = 0; v < 9; v++) begin
            check_translation(32'h0040_0000 + 32'(v) * 32'h1000, `SV32_ACC_STORE, 2);
        end
        check_translation(32'h0040_7000, `SV32_ACC_LOAD, 0);  // Eighth page still cached
        check_translation(32'h0040_0000, `SV32_ACC_LOAD, 2);  // First page replaced

        wait_idle();
        assert (exp_fault_q.size() == 0) else
            stop_with_failure("Requests ended with responses still missing");
        $display("Test completed successfully");
        $finish;
    end

endmodule

/* sv32_mmu.f */
+incdir+source
source/sv32_pkg.sv
source/sv32_tlb.sv
source/sv32_ptw.sv
source/sv32_perm_check.sv
source/sv32_mmu_top.sv
testbench/sv32_mmu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the sv32_mmu testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module sv32_mmu_tb -f sv32_mmu.f

sim_status=0
./obj_dir/Vsv32_mmu_tb > sim.log 2>&1 || sim_status=$?
cat sim.log

if grep -q "Test failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ "$sim_status" -ne 0 ]; then
    echo "Simulator exited with status $sim_status"
    exit 1
fi
if ! grep -q "Test completed successfully" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"
